// File: include/eth_mac_config.svh
`ifndef ETH_MAC_CONFIG_SVH
`define ETH_MAC_CONFIG_SVH

// stream and register port widths.
`define ETH_DATA_W      8
`define ETH_CSR_ADDR_W  5

// minimum frame length counts the FCS.
`define ETH_MIN_FRAME   64
`define ETH_IFG_DEFAULT 12

// register byte offsets.
`define ETH_REG_CTRL         5'h00
`define ETH_REG_TX_GOOD      5'h04
`define ETH_REG_TX_UNDERFLOW 5'h08
`define ETH_REG_RX_GOOD      5'h0C
`define ETH_REG_RX_BAD_FCS   5'h10
`define ETH_REG_RX_OVERFLOW  5'h14

// crc of a good frame with its FCS, in normal bit order.
`define ETH_CRC_RESIDUE 32'hC704DD7B

`endif

// File: rtl/eth_crc32.sv
`timescale 1ns/1ps
`include "eth_mac_config.svh"

module eth_crc32 (
    input  logic                   clk_sys,
    input  logic                   rst_n,
    input  logic                   clear,
    input  logic                   en,
    input  logic [`ETH_DATA_W-1:0] data,
    output logic [31:0]            crc
);

    // 0x04C11DB7 in reflected bit order.
    localparam logic [31:0] POLY_REFL = 32'hEDB8_8320;

    logic [31:0] state;
    logic [31:0] seed;
    logic [31:0] next;

    // clear together with en starts a new frame with this byte.
    always_comb begin
        seed = clear ? 32'hFFFF_FFFF : state;
        next = seed ^ 32'(data);
        for (int i = 0; i < `ETH_DATA_W; i++) begin
            next = next[0] ? ((next >> 1) ^ POLY_REFL) : (next >> 1);
        end
    end

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            state <= 32'hFFFF_FFFF;
        end else if (en) begin
            state <= next;
        end else if (clear) begin
            state <= 32'hFFFF_FFFF;
        end
    end

    // normal bit order.
    assign crc = {<<{state}};

endmodule

// File: rtl/eth_mac_csr.sv
`timescale 1ns/1ps
`include "eth_mac_config.svh"

module eth_mac_csr (
    input  logic                          clk_sys,
    input  logic                          rst_n,
    input  logic                          cpuif_req,
    input  logic                          cpuif_req_is_wr,
    input  logic [`ETH_CSR_ADDR_W-1:0]    cpuif_addr,
    input  logic [31:0]                   cpuif_wr_data,
    input  logic [31:0]                   cpuif_wr_biten,
    output logic                          cpuif_rd_ack,
    output logic                          cpuif_rd_err,
    output logic [31:0]                   cpuif_rd_data,
    output logic                          cpuif_wr_ack,
    output logic                          cpuif_wr_err,
    input  eth_mac_pkg::eth_stat_pulses_t stats,
    output eth_mac_pkg::eth_ctrl_u        ctrl
);

    localparam logic [31:0] CTRL_RESET = {16'h0000, 8'(`ETH_IFG_DEFAULT), 8'h00};

    logic [5:0]       sel;
    logic             hit;
    logic             wr_req;
    logic             rd_req;
    logic [4:0]       inc;
    logic [4:0][31:0] count;
    logic [31:0]      rd_mux;

    // sel[0] is the control word, sel[5:1] the counters in address order.
    always_comb begin
        sel = 6'b000000;
        case (cpuif_addr)
            `ETH_REG_CTRL:         sel[0] = 1'b1;
            `ETH_REG_TX_GOOD:      sel[1] = 1'b1;
            `ETH_REG_TX_UNDERFLOW: sel[2] = 1'b1;
            `ETH_REG_RX_GOOD:      sel[3] = 1'b1;
            `ETH_REG_RX_BAD_FCS:   sel[4] = 1'b1;
            `ETH_REG_RX_OVERFLOW:  sel[5] = 1'b1;
            default:               sel    = 6'b000000;
        endcase
    end

    assign hit    = |sel;
    assign wr_req = cpuif_req && cpuif_req_is_wr;
    assign rd_req = cpuif_req && !cpuif_req_is_wr;
    assign inc    = {stats.rx_overflow, stats.rx_bad_fcs, stats.rx_good,
                     stats.tx_underflow, stats.tx_good};

    // unmapped addresses read as zero.
    always_comb begin
        rd_mux = sel[0] ? ctrl.raw : 32'h0;
        for (int i = 0; i < 5; i++) begin
            if (sel[i+1]) begin
                rd_mux = count[i];
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            ctrl.raw      <= CTRL_RESET;
            count         <= '0;
            cpuif_rd_ack  <= 1'b0;
            cpuif_rd_err  <= 1'b0;
            cpuif_rd_data <= 32'h0;
            cpuif_wr_ack  <= 1'b0;
            cpuif_wr_err  <= 1'b0;
        end else begin
            cpuif_wr_ack  <= wr_req;
            cpuif_wr_err  <= wr_req && !hit;
            cpuif_rd_ack  <= rd_req;
            cpuif_rd_err  <= rd_req && !hit;
            cpuif_rd_data <= rd_req ? rd_mux : 32'h0;
            if (wr_req && sel[0]) begin
                ctrl.raw <= (ctrl.raw & ~cpuif_wr_biten) | (cpuif_wr_data & cpuif_wr_biten);
            end
            // a write clears the counter whatever the data.
            for (int i = 0; i < 5; i++) begin
                if (wr_req && sel[i+1]) begin
                    count[i] <= 32'h0;
                end else if (inc[i]) begin
                    count[i] <= count[i] + 32'h1;
                end
            end
        end
    end

endmodule

// File: rtl/eth_mac_pkg.sv
package eth_mac_pkg;

    // one MII nibble with its strobes.
    typedef struct packed {
        logic [3:0] d;
        logic       en;
        logic       er;
    } mii_nib_t;

    typedef struct packed {
        logic [15:0] rsvd_hi;
        logic [7:0]  ifg;
        logic [4:0]  rsvd_lo;
        logic        phy_rstn;
        logic        rx_en;
        logic        tx_en;
    } eth_ctrl_fields_t;

    // written as a word by the CSR block, read by field in the datapaths.
    typedef union packed {
        logic [31:0]      raw;
        eth_ctrl_fields_t f;
    } eth_ctrl_u;

    // single-cycle event pulses into the counters.
    typedef struct packed {
        logic tx_good;
        logic tx_underflow;
        logic rx_good;
        logic rx_bad_fcs;
        logic rx_overflow;
    } eth_stat_pulses_t;

endpackage

// File: rtl/eth_mii_rx.sv
`timescale 1ns/1ps
`include "eth_mac_config.svh"

module eth_mii_rx (
    input  logic                   clk_sys,
    input  logic                   rst_n,
    input  eth_mac_pkg::eth_ctrl_u ctrl,
    input  eth_mac_pkg::mii_nib_t  mii_rx,
    output logic [`ETH_DATA_W-1:0] rx_tdata,
    output logic                   rx_tvalid,
    input  logic                   rx_tready,
    output logic                   rx_tlast,
    output logic                   rx_tuser,
    output logic                   rx_good,
    output logic                   rx_bad_fcs,
    output logic                   rx_overflow
);

    logic                        in_frame;
    logic                        phase;
    logic [3:0]                  lo_nib;
    logic [`ETH_DATA_W-1:0]      new_byte;
    logic [3:0][`ETH_DATA_W-1:0] dl;
    logic [2:0]                  dl_cnt;
    logic [`ETH_DATA_W-1:0]      pend;
    logic                        pend_vld;
    logic                        er_seen;
    logic                        ovf_seen;
    logic [31:0]                 crc;
    logic                        sfd;
    logic                        byte_done;
    logic                        frame_end;
    logic                        offer;
    logic                        drop;
    logic                        bad;

    // preamble nibbles are 5, so the first D is the high half of the SFD.
    assign sfd       = !in_frame && ctrl.f.rx_en && mii_rx.en && mii_rx.d == 4'hD;
    assign byte_done = in_frame && mii_rx.en && phase;
    assign frame_end = in_frame && !mii_rx.en;
    assign new_byte  = {mii_rx.d, lo_nib};

    // pend has four newer bytes behind it, so it is never FCS.
    assign offer = pend_vld && ((byte_done && dl_cnt == 3'd4) || frame_end);
    assign drop  = offer && rx_tvalid && !rx_tready;
    assign bad   = er_seen || ovf_seen || drop || phase || crc != `ETH_CRC_RESIDUE;

    eth_crc32 u_crc (
        .clk_sys (clk_sys),
        .rst_n   (rst_n),
        .clear   (sfd),
        .en      (byte_done),
        .data    (new_byte),
        .crc     (crc)
    );

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            in_frame    <= 1'b0;
            phase       <= 1'b0;
            dl_cnt      <= 3'd0;
            pend_vld    <= 1'b0;
            er_seen     <= 1'b0;
            ovf_seen    <= 1'b0;
            rx_tvalid   <= 1'b0;
            rx_tlast    <= 1'b0;
            rx_tuser    <= 1'b0;
            rx_good     <= 1'b0;
            rx_bad_fcs  <= 1'b0;
            rx_overflow <= 1'b0;
        end else begin
            rx_good     <= 1'b0;
            rx_bad_fcs  <= 1'b0;
            // one overflow event per frame.
            rx_overflow <= drop && !ovf_seen;
            if (rx_tvalid && rx_tready) begin
                rx_tvalid <= 1'b0;
            end
            if (offer) begin
                rx_tvalid <= 1'b1;
                rx_tlast  <= frame_end;
                rx_tuser  <= frame_end && bad;
            end
            if (sfd) begin
                in_frame <= 1'b1;
                phase    <= 1'b0;
                dl_cnt   <= 3'd0;
                pend_vld <= 1'b0;
                er_seen  <= 1'b0;
                ovf_seen <= 1'b0;
            end else if (frame_end) begin
                in_frame   <= 1'b0;
                rx_good    <= !bad;
                rx_bad_fcs <= bad;
            end else if (in_frame) begin
                phase    <= !phase;
                er_seen  <= er_seen || mii_rx.er;
                ovf_seen <= ovf_seen || drop;
                if (byte_done && dl_cnt != 3'd4) begin
                    dl_cnt <= dl_cnt + 3'd1;
                end else if (byte_done) begin
                    pend_vld <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (in_frame && mii_rx.en && !phase) begin
            lo_nib <= mii_rx.d;
        end
        if (byte_done) begin
            dl   <= {dl[2:0], new_byte};
            pend <= dl[3];
        end
        if (offer) begin
            rx_tdata <= pend;
        end
    end

endmodule

// File: rtl/eth_mii_tx.sv
`timescale 1ns/1ps
`include "eth_mac_config.svh"

module eth_mii_tx (
    input  logic                   clk_sys,
    input  logic                   rst_n,
    input  eth_mac_pkg::eth_ctrl_u ctrl,
    input  logic [`ETH_DATA_W-1:0] tx_tdata,
    input  logic                   tx_tvalid,
    output logic                   tx_tready,
    input  logic                   tx_tlast,
    output eth_mac_pkg::mii_nib_t  mii_tx,
    output logic                   tx_good,
    output logic                   tx_underflow
);

    localparam logic [7:0] PAD_BYTES = 8'(`ETH_MIN_FRAME - 4);

    typedef enum logic [2:0] {
        S_IDLE,
        S_PRE,
        S_DATA,
        S_PAD,
        S_FCS,
        S_GAP,
        S_DRAIN
    } state_t;

    state_t                 state;
    logic                   phase;
    logic [7:0]             cnt;
    logic [`ETH_DATA_W-1:0] cur_byte;
    logic [`ETH_DATA_W-1:0] out_byte;
    logic                   last_q;
    logic                   err_q;
    logic [31:0]            crc;
    logic [31:0]            fcs;
    logic                   start;
    logic                   data_due;
    logic                   take;
    logic                   pad_load;
    logic                   gap_done;
    logic                   on_wire;

    assign start    = ctrl.f.tx_en && tx_tvalid;
    assign data_due = phase && ((state == S_PRE && cnt == 8'd7) ||
                                (state == S_DATA && !last_q));
    assign take     = data_due && tx_tvalid;
    assign pad_load = phase && cnt < PAD_BYTES &&
                      ((state == S_DATA && last_q) || state == S_PAD);
    assign gap_done = phase && ({1'b0, cnt} + 9'd1 >= {1'b0, ctrl.f.ifg});
    assign on_wire  = state inside {S_PRE, S_DATA, S_PAD, S_FCS};

    // FCS goes out complemented, low byte first.
    assign fcs      = ~{<<{crc}};
    assign out_byte = (state == S_FCS) ? fcs[{cnt[1:0], 3'b000} +: 8] : cur_byte;

    assign tx_tready    = data_due || state == S_DRAIN;
    assign tx_underflow = err_q;

    always_comb begin
        mii_tx.d  = on_wire ? (phase ? out_byte[7:4] : out_byte[3:0]) : 4'h0;
        mii_tx.en = on_wire || err_q;
        mii_tx.er = err_q;
    end

    eth_crc32 u_crc (
        .clk_sys (clk_sys),
        .rst_n   (rst_n),
        .clear   (state == S_PRE),
        .en      (take || pad_load),
        .data    (take ? tx_tdata : 8'h00),
        .crc     (crc)
    );

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            state   <= S_IDLE;
            phase   <= 1'b0;
            cnt     <= 8'd0;
            last_q  <= 1'b0;
            err_q   <= 1'b0;
            tx_good <= 1'b0;
        end else begin
            phase   <= !phase;
            err_q   <= 1'b0;
            tx_good <= 1'b0;
            case (state)
                S_IDLE: begin
                    phase <= 1'b0;
                    cnt   <= 8'd0;
                    if (start) begin
                        state <= S_PRE;
                    end
                end
                S_PRE: begin
                    if (phase && cnt != 8'd7) begin
                        cnt <= cnt + 8'd1;
                    end else if (take) begin
                        state  <= S_DATA;
                        cnt    <= 8'd1;
                        last_q <= tx_tlast;
                    end else if (data_due) begin
                        state <= S_DRAIN;
                        err_q <= 1'b1;
                    end
                end
                S_DATA: begin
                    if (take) begin
                        // count saturates once padding can no longer apply.
                        cnt    <= (cnt < PAD_BYTES) ? cnt + 8'd1 : cnt;
                        last_q <= tx_tlast;
                    end else if (data_due) begin
                        state <= S_DRAIN;
                        err_q <= 1'b1;
                    end else if (pad_load) begin
                        state <= S_PAD;
                        cnt   <= cnt + 8'd1;
                    end else if (phase) begin
                        state <= S_FCS;
                        cnt   <= 8'd0;
                    end
                end
                S_PAD: begin
                    if (pad_load) begin
                        cnt <= cnt + 8'd1;
                    end else if (phase) begin
                        state <= S_FCS;
                        cnt   <= 8'd0;
                    end
                end
                S_FCS: begin
                    if (phase && cnt == 8'd3) begin
                        state   <= S_GAP;
                        cnt     <= 8'd0;
                        tx_good <= 1'b1;
                    end else if (phase) begin
                        cnt <= cnt + 8'd1;
                    end
                end
                S_GAP: begin
                    if (gap_done) begin
                        cnt   <= 8'd0;
                        state <= start ? S_PRE : S_IDLE;
                    end else if (phase) begin
                        cnt <= cnt + 8'd1;
                    end
                end
                default: begin
                    // discard the rest of an underflowed frame.
                    phase <= 1'b0;
                    if (tx_tvalid && tx_tlast) begin
                        state <= S_GAP;
                        cnt   <= 8'd0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_sys) begin
        if (take) begin
            cur_byte <= tx_tdata;
        end else if (pad_load) begin
            cur_byte <= 8'h00;
        end else if (state == S_PRE && phase && cnt == 8'd6) begin
            cur_byte <= 8'hD5;
        end else if (state inside {S_IDLE, S_GAP}) begin
            cur_byte <= 8'h55;
        end
    end

endmodule

// File: rtl/eth_wrapper.sv
`timescale 1ns/1ps
`include "eth_mac_config.svh"

module eth_wrapper (
    input  logic                       clk_sys,
    input  logic                       rst_n,

    input  logic [`ETH_DATA_W-1:0]     tx_tdata,
    input  logic                       tx_tvalid,
    output logic                       tx_tready,
    input  logic                       tx_tlast,

    output logic [`ETH_DATA_W-1:0]     rx_tdata,
    output logic                       rx_tvalid,
    input  logic                       rx_tready,
    output logic                       rx_tlast,
    output logic                       rx_tuser,

    output eth_mac_pkg::mii_nib_t      mii_tx,
    input  eth_mac_pkg::mii_nib_t      mii_rx,
    output logic                       phy_rstn,

    input  logic                       cpuif_req,
    input  logic                       cpuif_req_is_wr,
    input  logic [`ETH_CSR_ADDR_W-1:0] cpuif_addr,
    input  logic [31:0]                cpuif_wr_data,
    input  logic [31:0]                cpuif_wr_biten,
    output logic                       cpuif_rd_ack,
    output logic                       cpuif_rd_err,
    output logic [31:0]                cpuif_rd_data,
    output logic                       cpuif_wr_ack,
    output logic                       cpuif_wr_err
);

    import eth_mac_pkg::*;

    eth_ctrl_u        ctrl;
    eth_stat_pulses_t stats;

    eth_mac_csr u_csr (
        .clk_sys         (clk_sys),
        .rst_n           (rst_n),
        .cpuif_req       (cpuif_req),
        .cpuif_req_is_wr (cpuif_req_is_wr),
        .cpuif_addr      (cpuif_addr),
        .cpuif_wr_data   (cpuif_wr_data),
        .cpuif_wr_biten  (cpuif_wr_biten),
        .cpuif_rd_ack    (cpuif_rd_ack),
        .cpuif_rd_err    (cpuif_rd_err),
        .cpuif_rd_data   (cpuif_rd_data),
        .cpuif_wr_ack    (cpuif_wr_ack),
        .cpuif_wr_err    (cpuif_wr_err),
        .stats           (stats),
        .ctrl            (ctrl)
    );

    assign phy_rstn = ctrl.f.phy_rstn;

    eth_mii_tx u_tx (
        .clk_sys      (clk_sys),
        .rst_n        (rst_n),
        .ctrl         (ctrl),
        .tx_tdata     (tx_tdata),
        .tx_tvalid    (tx_tvalid),
        .tx_tready    (tx_tready),
        .tx_tlast     (tx_tlast),
        .mii_tx       (mii_tx),
        .tx_good      (stats.tx_good),
        .tx_underflow (stats.tx_underflow)
    );

    eth_mii_rx u_rx (
        .clk_sys     (clk_sys),
        .rst_n       (rst_n),
        .ctrl        (ctrl),
        .mii_rx      (mii_rx),
        .rx_tdata    (rx_tdata),
        .rx_tvalid   (rx_tvalid),
        .rx_tready   (rx_tready),
        .rx_tlast    (rx_tlast),
        .rx_tuser    (rx_tuser),
        .rx_good     (stats.rx_good),
        .rx_bad_fcs  (stats.rx_bad_fcs),
        .rx_overflow (stats.rx_overflow)
    );

endmodule

// File: run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f sim.f --top-module eth_wrapper_tb \
    && ./obj_dir/Veth_wrapper_tb | tee sim.log \
    && grep -qx "STATUS: PASS" sim.log \
    || { echo "simulation did not pass"; exit 1; }

// File: sim.f
+incdir+include
rtl/eth_mac_pkg.sv
rtl/eth_crc32.sv
rtl/eth_mii_tx.sv
rtl/eth_mii_rx.sv
rtl/eth_mac_csr.sv
rtl/eth_wrapper.sv
test/eth_wrapper_tb.sv

// File: test/eth_wrapper_tb.sv
`timescale 1ns/1ps
`include "eth_mac_config.svh"

module eth_wrapper_tb;

    import eth_mac_pkg::*;

    typedef logic [7:0] byte_q_t[$];

    localparam logic [4:0] CNT_ADDR [5] = '{`ETH_REG_TX_GOOD, `ETH_REG_TX_UNDERFLOW,
                                            `ETH_REG_RX_GOOD, `ETH_REG_RX_BAD_FCS,
                                            `ETH_REG_RX_OVERFLOW};

    logic        clk_sys;
    logic        rst_n;
    logic [7:0]  tx_tdata;
    logic        tx_tvalid;
    logic        tx_tready;
    logic        tx_tlast;
    logic [7:0]  rx_tdata;
    logic        rx_tvalid;
    logic        rx_tready;
    logic        rx_tlast;
    logic        rx_tuser;
    mii_nib_t    mii_tx;
    mii_nib_t    mii_rx;
    mii_nib_t    inj_nib;
    logic        loopback;
    logic        phy_rstn;
    logic        cpuif_req;
    logic        cpuif_req_is_wr;
    logic [4:0]  cpuif_addr;
    logic [31:0] cpuif_wr_data;
    logic [31:0] cpuif_wr_biten;
    logic        cpuif_rd_ack;
    logic        cpuif_rd_err;
    logic [31:0] cpuif_rd_data;
    logic        cpuif_wr_ack;
    logic        cpuif_wr_err;

    int          errors;
    int          checks;
    logic [31:0] lcg_state;
    logic [7:0]  rx_q[$];
    logic        rx_last_q[$];
    logic        rx_user_q[$];
    int          rx_frames;
    logic [3:0]  tx_nib_q[$];
    int          gap_q[$];
    int          low_cnt;
    logic        prev_en;
    logic        tx_er_seen;

    always #10 clk_sys = ~clk_sys;

    // rx side sees either the tx wire or the nibble driver.
    assign mii_rx = loopback ? mii_tx : inj_nib;

    eth_wrapper eth_wrapper_inst (.*);

    ack_follows_req: assert property (@(posedge clk_sys) disable iff (!rst_n)
        cpuif_req |=> (cpuif_wr_ack || cpuif_rd_ack))
    else begin
        $display("[FAIL] cpuif_wr_ack=0x%h cpuif_rd_ack=0x%h after request",
                 cpuif_wr_ack, cpuif_rd_ack);
        errors++;
    end

    // outputs are sampled mid-cycle, away from the edges.
    always @(negedge clk_sys) begin
        if (rst_n) begin
            if (rx_tvalid && rx_tready) begin
                rx_q.push_back(rx_tdata);
                rx_last_q.push_back(rx_tlast);
                rx_user_q.push_back(rx_tuser);
                if (rx_tlast) begin
                    rx_frames++;
                end
            end
            if (mii_tx.en) begin
                tx_nib_q.push_back(mii_tx.d);
            end
            if (mii_tx.er) begin
                tx_er_seen = 1'b1;
            end
            if (!mii_tx.en) begin
                low_cnt++;
            end else begin
                if (!prev_en) begin
                    gap_q.push_back(low_cnt);
                end
                low_cnt = 0;
            end
            prev_en = mii_tx.en;
        end
    end

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    function automatic logic [7:0] lcg_byte();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    function automatic byte_q_t random_payload(input int n);
        byte_q_t p;
        for (int i = 0; i < n; i++) begin
            p.push_back(lcg_byte());
        end
        return p;
    endfunction

    // reflected CRC-32, complemented, as the FCS goes on the wire.
    function automatic logic [31:0] ref_fcs(input byte_q_t bytes);
        logic [31:0] c;
        c = 32'hFFFF_FFFF;
        foreach (bytes[i]) begin
            c = c ^ {24'h0, bytes[i]};
            for (int b = 0; b < 8; b++) begin
                c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
            end
        end
        return ~c;
    endfunction

    function automatic byte_q_t padded(input byte_q_t p);
        byte_q_t r;
        r = p;
        while (r.size() < `ETH_MIN_FRAME - 4) begin
            r.push_back(8'h00);
        end
        return r;
    endfunction

    // called and left at 2 ns after a rising edge.
    task automatic reg_access(input logic is_wr, input logic [4:0] addr,
                              input logic [31:0] wdata, input logic [31:0] biten,
                              output logic [31:0] rdata, output logic err);
        cpuif_req       = 1'b1;
        cpuif_req_is_wr = is_wr;
        cpuif_addr      = addr;
        cpuif_wr_data   = wdata;
        cpuif_wr_biten  = biten;
        @(negedge clk_sys);
        check_eq("cpuif_wr_ack", 32'(cpuif_wr_ack), 32'h0);
        check_eq("cpuif_rd_ack", 32'(cpuif_rd_ack), 32'h0);
        @(posedge clk_sys);
        #2;
        cpuif_req = 1'b0;
        @(negedge clk_sys);
        check_eq(is_wr ? "cpuif_wr_ack" : "cpuif_rd_ack",
                 32'(is_wr ? cpuif_wr_ack : cpuif_rd_ack), 32'h1);
        rdata = cpuif_rd_data;
        err   = is_wr ? cpuif_wr_err : cpuif_rd_err;
        @(posedge clk_sys);
        #2;
    endtask

    task automatic reg_write(input logic [4:0] addr, input logic [31:0] data,
                             input logic [31:0] biten, input logic exp_err);
        logic [31:0] rd;
        logic        err;
        reg_access(1'b1, addr, data, biten, rd, err);
        check_eq("cpuif_wr_err", 32'(err), 32'(exp_err));
    endtask

    task automatic reg_read_check(input logic [4:0] addr, input logic [31:0] exp,
                                  input logic exp_err);
        logic [31:0] rd;
        logic        err;
        reg_access(1'b0, addr, 32'h0, 32'h0, rd, err);
        check_eq("cpuif_rd_data", rd, exp);
        check_eq("cpuif_rd_err", 32'(err), 32'(exp_err));
    endtask

    task automatic clear_counters();
        for (int i = 0; i < 5; i++) begin
            reg_write(CNT_ADDR[i], 32'h0, 32'hFFFF_FFFF, 1'b0);
        end
    endtask

    // valid drops for 10 cycles before byte gap_at; -1 keeps it high.
    task automatic send_frame(input byte_q_t payload, input int gap_at);
        int t;
        for (int i = 0; i < payload.size(); i++) begin
            if (i == gap_at) begin
                tx_tvalid = 1'b0;
                repeat (10) @(posedge clk_sys);
                #2;
            end
            tx_tdata  = payload[i];
            tx_tvalid = 1'b1;
            tx_tlast  = (i == payload.size() - 1);
            t = 0;
            @(negedge clk_sys);
            while (!tx_tready && t < 2000) begin
                t++;
                @(negedge clk_sys);
            end
            if (!tx_tready) begin
                $display("timeout waiting for tx_tready at byte %0d", i);
                errors++;
            end
            @(posedge clk_sys);
            #2;
        end
        tx_tvalid = 1'b0;
        tx_tlast  = 1'b0;
    endtask

    task automatic inject_frame(input byte_q_t payload, input logic corrupt);
        byte_q_t     fr;
        logic [31:0] fcs;
        fcs = ref_fcs(payload);
        for (int i = 0; i < 7; i++) begin
            fr.push_back(8'h55);
        end
        fr.push_back(8'hD5);
        foreach (payload[i]) begin
            fr.push_back(payload[i]);
        end
        for (int i = 0; i < 4; i++) begin
            fr.push_back(fcs[8*i +: 8]);
        end
        if (corrupt) begin
            fr[fr.size()-1] = ~fr[fr.size()-1];
        end
        foreach (fr[i]) begin
            inj_nib.d  = fr[i][3:0];
            inj_nib.en = 1'b1;
            inj_nib.er = 1'b0;
            @(posedge clk_sys);
            #2;
            inj_nib.d = fr[i][7:4];
            @(posedge clk_sys);
            #2;
        end
        inj_nib = '0;
    endtask

    task automatic wait_rx_frame(output logic ok);
        int t;
        t = 0;
        while (rx_frames == 0 && t < 5000) begin
            t++;
            @(posedge clk_sys);
            #2;
        end
        ok = (rx_frames != 0);
        if (!ok) begin
            $display("timeout waiting for an rx frame");
            errors++;
        end else begin
            rx_frames--;
        end
    endtask

    task automatic check_rx_frame(input byte_q_t exp, input logic exp_user);
        logic ok;
        logic l;
        logic u;
        wait_rx_frame(ok);
        if (ok) begin
            foreach (exp[i]) begin
                l = rx_last_q.pop_front();
                u = rx_user_q.pop_front();
                check_eq("rx_tdata", 32'(rx_q.pop_front()), 32'(exp[i]));
                check_eq("rx_tlast", 32'(l), 32'(i == exp.size() - 1));
                if (l) begin
                    check_eq("rx_tuser", 32'(u), 32'(exp_user));
                    break;
                end
            end
        end
    endtask

    // two frames with no pause in tx_tvalid, then the idle gap between them.
    task automatic back_to_back(input int n1, input int n2, input int exp_gap);
        byte_q_t p1;
        byte_q_t p2;
        int      t;
        p1 = random_payload(n1);
        p2 = random_payload(n2);
        fork
            begin
                send_frame(p1, -1);
                send_frame(p2, -1);
            end
            begin
                gap_q.delete();
                t = 0;
                while (gap_q.size() == 0 && t < 2000) begin
                    t++;
                    @(posedge clk_sys);
                end
                if (gap_q.size() == 0) begin
                    $display("timeout waiting for the first frame on mii_tx");
                    errors++;
                end
                gap_q.delete();
            end
        join
        check_rx_frame(padded(p1), 1'b0);
        check_rx_frame(padded(p2), 1'b0);
        check_eq("gap count", 32'(gap_q.size()), 32'h1);
        if (gap_q.size() != 0) begin
            check_eq("mii_tx.en idle gap", 32'(gap_q[0]), 32'(exp_gap));
        end
    endtask

    initial begin
        #2ms;
        $display("simulation watchdog expired");
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        byte_q_t    p;
        logic       ok;
        logic [3:0] exp_nib;
        int         wait_cnt;
        clk_sys         = 1'b0;
        rst_n           = 1'b0;
        tx_tdata        = 8'h00;
        tx_tvalid       = 1'b0;
        tx_tlast        = 1'b0;
        rx_tready       = 1'b1;
        inj_nib         = '0;
        loopback        = 1'b1;
        cpuif_req       = 1'b0;
        cpuif_req_is_wr = 1'b0;
        cpuif_addr      = 5'h00;
        cpuif_wr_data   = 32'h0;
        cpuif_wr_biten  = 32'h0;
        errors          = 0;
        checks          = 0;
        rx_frames       = 0;
        low_cnt         = 0;
        prev_en         = 1'b0;
        tx_er_seen      = 1'b0;
        lcg_state       = 32'h728b_bc8c;
        repeat (2) @(posedge clk_sys);
        #2;
        rst_n = 1'b1;

        // reset state and a frame offered with tx disabled.
        @(negedge clk_sys);
        check_eq("phy_rstn", 32'(phy_rstn), 32'h0);
        check_eq("mii_tx.en", 32'(mii_tx.en), 32'h0);
        check_eq("tx_tready", 32'(tx_tready), 32'h0);
        check_eq("rx_tvalid", 32'(rx_tvalid), 32'h0);
        @(posedge clk_sys);
        #2;
        reg_read_check(`ETH_REG_CTRL, 32'h0000_0C00, 1'b0);
        for (int i = 0; i < 5; i++) begin
            reg_read_check(CNT_ADDR[i], 32'h0, 1'b0);
        end
        tx_tdata  = lcg_byte();
        tx_tvalid = 1'b1;
        tx_tlast  = 1'b1;
        repeat (200) begin
            @(negedge clk_sys);
            check_eq("mii_tx.en", 32'(mii_tx.en), 32'h0);
        end
        @(posedge clk_sys);
        #2;
        tx_tvalid = 1'b0;
        tx_tlast  = 1'b0;

        // short frame through loopback.
        reg_write(`ETH_REG_CTRL, 32'h0000_0C07, 32'hFFFF_FFFF, 1'b0);
        check_eq("phy_rstn", 32'(phy_rstn), 32'h1);
        p = random_payload(20);
        tx_nib_q.delete();
        send_frame(p, -1);
        check_rx_frame(padded(p), 1'b0);
        for (int i = 0; i < 16; i++) begin
            exp_nib = (i == 15) ? 4'hD : 4'h5;
            check_eq("mii_tx.d", 32'(tx_nib_q[i]), 32'(exp_nib));
        end
        reg_read_check(`ETH_REG_TX_GOOD, 32'h1, 1'b0);
        reg_read_check(`ETH_REG_RX_GOOD, 32'h1, 1'b0);

        // long frames back to back, then again with a wider gap.
        back_to_back(100, 80, 24);
        reg_write(`ETH_REG_CTRL, 32'h0000_1400, 32'h0000_FF00, 1'b0);
        reg_read_check(`ETH_REG_CTRL, 32'h0000_1407, 1'b0);
        back_to_back(30, 30, 40);

        // injected frames, bad FCS first.
        loopback = 1'b0;
        clear_counters();
        p = random_payload(60);
        inject_frame(p, 1'b1);
        check_rx_frame(p, 1'b1);
        reg_read_check(`ETH_REG_RX_BAD_FCS, 32'h1, 1'b0);
        inject_frame(p, 1'b0);
        check_rx_frame(p, 1'b0);
        reg_read_check(`ETH_REG_RX_GOOD, 32'h1, 1'b0);

        // rx back-pressure for a whole loopback frame.
        loopback  = 1'b1;
        rx_tready = 1'b0;
        clear_counters();
        send_frame(random_payload(20), -1);
        ok = 1'b0;
        for (int t = 0; t < 2000 && !ok; t++) begin
            @(negedge clk_sys);
            ok = rx_tvalid && rx_tlast;
        end
        if (!ok) begin
            $display("timeout waiting for the last rx byte under back-pressure");
            errors++;
        end
        @(posedge clk_sys);
        #2;
        rx_tready = 1'b1;
        wait_rx_frame(ok);
        if (ok) begin
            void'(rx_q.pop_front());
            check_eq("rx_tlast", 32'(rx_last_q.pop_front()), 32'h1);
            check_eq("rx_tuser", 32'(rx_user_q.pop_front()), 32'h1);
        end
        reg_read_check(`ETH_REG_RX_OVERFLOW, 32'h1, 1'b0);

        // tx underflow mid-frame.
        loopback   = 1'b0;
        clear_counters();
        tx_er_seen = 1'b0;
        send_frame(random_payload(30), 10);
        wait_cnt = 0;
        while (!tx_er_seen && wait_cnt < 200) begin
            wait_cnt++;
            @(posedge clk_sys);
            #2;
        end
        check_eq("mii_tx.er seen", 32'(tx_er_seen), 32'h1);
        reg_read_check(`ETH_REG_TX_UNDERFLOW, 32'h1, 1'b0);

        // unmapped address and counter clear.
        reg_read_check(5'h1C, 32'h0, 1'b1);
        reg_write(5'h1C, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 1'b1);
        reg_write(`ETH_REG_TX_UNDERFLOW, 32'h1234_5678, 32'hFFFF_FFFF, 1'b0);
        reg_read_check(`ETH_REG_TX_UNDERFLOW, 32'h0, 1'b0);

        $display("checks=%0d errors=%0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
